/* Makefile */
# Verilator build and run for the integer divide unit testbench

VERILATOR ?= verilator
TOP       ?= tb_div_unit
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary -j 0 -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log is searched for the pass line, anything else counts as failure
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/div_pkg.sv */
////////////////////
// shared definitions for the divide unit
// operation encoding, sideband struct and width constants
////////////////////

`default_nettype none

package div_pkg;

	////////////////////
	// widths
	////////////////////

	// data width of the integer datapath
	localparam int XLEN = 32;
	// destination register tag carried with each operation
	localparam int TAG_W = 5;

	// one bit per divider stage, msb is the first stage
	// a set bit puts a register after that stage, this one gives eight
	localparam logic [XLEN-1:0] STAGE_LIST_DEFAULT = 32'h1111_1111;

	////////////////////
	// types
	////////////////////

	// the four divide operations of the M extension
	typedef enum logic [1:0] {
		DIV  = 2'b00,
		DIVU = 2'b01,
		REM  = 2'b10,
		REMU = 2'b11
	} div_op_t;

	// flags that ride beside the data through the unsigned core
	// fixup only applies them and never looks at the operation again
	typedef struct packed {
		logic             neg_quo;
		logic             neg_rem;
		logic             sel_rem;
		logic [TAG_W-1:0] tag;
	} div_side_t;

endpackage

`default_nettype wire

/* compile.f */
+incdir+verification
common/div_pkg.sv
divider/div_operand_prep.sv
divider/div_restoring_pipe.sv
divider/div_result_fixup.sv
divider/div_unit.sv
verification/tb_div_unit.sv

/* divider/div_operand_prep.sv */
////////////////////
// operand preparation for the divide unit
// decodes the operation, forms magnitudes and the sideband
////////////////////

`timescale 1ns/1ps
`default_nettype none

module div_operand_prep (
	input  logic                     i_valid,
	input  div_pkg::div_op_t         i_op,
	input  logic [div_pkg::XLEN-1:0] i_a,
	input  logic [div_pkg::XLEN-1:0] i_b,
	input  logic [div_pkg::TAG_W-1:0] i_tag,
	output logic                     o_valid,
	output logic [div_pkg::XLEN-1:0] o_mag_a,
	output logic [div_pkg::XLEN-1:0] o_mag_b,
	output div_pkg::div_side_t       o_side
);

	import div_pkg::*;

	// decoded operation
	logic is_signed;
	logic want_rem;

	// sign and zero information on the raw operands
	logic a_neg;
	logic b_neg;
	logic b_zero;

	// DIV and REM treat the operands as two's complement
	assign is_signed = (i_op == DIV) || (i_op == REM);
	// REM and REMU return the remainder
	assign want_rem = (i_op == REM) || (i_op == REMU);

	// an operand only counts as negative for the signed forms
	assign a_neg = is_signed && i_a[XLEN-1];
	assign b_neg = is_signed && i_b[XLEN-1];
	assign b_zero = (i_b == '0);

	////////////////////
	// magnitudes
	////////////////////

	// the most negative value negates to itself, which is still its magnitude
	// when read as unsigned, so the overflow case needs nothing extra
	assign o_mag_a = a_neg ? (~i_a + 1'b1) : i_a;
	assign o_mag_b = b_neg ? (~i_b + 1'b1) : i_b;

	////////////////////
	// sideband
	////////////////////

	always_comb begin
		// the quotient is negative when the signs differ
		// on a zero divisor the core already gives all ones, which must stay -1
		o_side.neg_quo = a_neg ^ b_neg;
		if (b_zero) begin
			o_side.neg_quo = 1'b0;
		end
		// remainder takes the sign of the dividend
		o_side.neg_rem = a_neg;
		o_side.sel_rem = want_rem;
		o_side.tag     = i_tag;
	end

	// preparation is purely combinational, the strobe goes straight on
	assign o_valid = i_valid;

endmodule

`default_nettype wire

/* divider/div_restoring_pipe.sv */
////////////////////
// unsigned restoring divider, one quotient bit per stage
// a register follows each stage whose mask bit is set
////////////////////

`timescale 1ns/1ps
`default_nettype none

module div_restoring_pipe #(
	parameter int              XLEN       = 32,
	parameter logic [XLEN-1:0] STAGE_LIST = '1,
	parameter type             side_t     = logic
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_valid,
	input  logic [XLEN-1:0] i_dividend,
	input  logic [XLEN-1:0] i_divisor,
	input  side_t           i_side,
	output logic            o_valid,
	output logic [XLEN-1:0] o_quotient,
	output logic [XLEN-1:0] o_remainder,
	output side_t           o_side
);

	// entry k is the state in front of stage k, entry XLEN is the result
	// work holds the partial remainder in its upper bits and the dividend
	// bits still to be consumed in its lower bits
	logic            vld    [XLEN+1];
	logic [XLEN-1:0] work   [XLEN+1];
	logic [XLEN-1:0] dvs    [XLEN+1];
	logic [XLEN-1:0] quo    [XLEN+1];
	side_t           side_s [XLEN+1];

	assign vld[0]    = i_valid;
	assign work[0]   = i_dividend;
	assign dvs[0]    = i_divisor;
	assign quo[0]    = '0;
	assign side_s[0] = i_side;

	////////////////////
	// stages
	////////////////////

	for (genvar i = 0; i < XLEN; i++) begin : g_stage
		// stage i looks at the top i+1 bits of the work word
		localparam int W = i + 1;

		logic [W-1:0]    part;
		logic [W-1:0]    dvs_low;
		logic            too_big;
		logic            q_bit;
		logic [W-1:0]    diff;
		logic [XLEN-1:0] nxt_work;
		logic [XLEN-1:0] nxt_quo;

		assign part    = work[i][XLEN-1 -: W];
		assign dvs_low = dvs[i][W-1:0];

		// any divisor bit above the window means it cannot fit yet
		assign too_big = |(dvs[i] >> W);
		assign q_bit   = !too_big && (part >= dvs_low);

		// restore by keeping the old value when the subtract is refused
		assign diff = q_bit ? (part - dvs_low) : part;

		if (W < XLEN) begin : g_merge
			assign nxt_work = {diff, work[i][XLEN-W-1:0]};
		end else begin : g_last
			// last stage, the whole word is now the remainder
			assign nxt_work = diff;
		end

		// quotient bits are produced msb first
		assign nxt_quo = quo[i] | ({{(XLEN-1){1'b0}}, q_bit} << (XLEN - W));

		// mask msb belongs to the first stage
		if (STAGE_LIST[XLEN-W]) begin : g_reg
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					vld[i+1]    <= 1'b0;
					work[i+1]   <= '0;
					dvs[i+1]    <= '0;
					quo[i+1]    <= '0;
					side_s[i+1] <= '0;
				end else begin
					vld[i+1]    <= vld[i];
					work[i+1]   <= nxt_work;
					dvs[i+1]    <= dvs[i];
					quo[i+1]    <= nxt_quo;
					side_s[i+1] <= side_s[i];
				end
			end
		end else begin : g_comb
			assign vld[i+1]    = vld[i];
			assign work[i+1]   = nxt_work;
			assign dvs[i+1]    = dvs[i];
			assign quo[i+1]    = nxt_quo;
			assign side_s[i+1] = side_s[i];
		end
	end

	////////////////////
	// outputs
	////////////////////

	assign o_valid     = vld[XLEN];
	assign o_quotient  = quo[XLEN];
	assign o_remainder = work[XLEN];
	assign o_side      = side_s[XLEN];

endmodule

`default_nettype wire

/* divider/div_result_fixup.sv */
////////////////////
// result correction for the divide unit
// sign fixup, quotient or remainder select, output register
////////////////////

`timescale 1ns/1ps
`default_nettype none

module div_result_fixup #(
	parameter int XLEN  = 32,
	parameter int TAG_W = 5
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_valid,
	input  logic [XLEN-1:0]    i_quotient,
	input  logic [XLEN-1:0]    i_remainder,
	input  div_pkg::div_side_t i_side,
	output logic               o_valid,
	output logic [XLEN-1:0]    o_result,
	output logic [TAG_W-1:0]   o_tag
);

	// signed versions of the unsigned core results
	logic [XLEN-1:0] quo_fix;
	logic [XLEN-1:0] rem_fix;
	// value that goes into the output register
	logic [XLEN-1:0] result_d;

	////////////////////
	// sign correction
	////////////////////

	// the flags were decided at the input, only apply them here
	// two's complement negation covers the overflow case as well,
	// since the magnitude 0x8000_0000 negates back to itself
	assign quo_fix = i_side.neg_quo ? (~i_quotient + 1'b1) : i_quotient;
	assign rem_fix = i_side.neg_rem ? (~i_remainder + 1'b1) : i_remainder;

	// REM and REMU take the remainder, DIV and DIVU the quotient
	assign result_d = i_side.sel_rem ? rem_fix : quo_fix;

	////////////////////
	// output register
	////////////////////

	// one cycle through here, result and tag change together
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_valid  <= 1'b0;
			o_result <= '0;
			o_tag    <= '0;
		end else begin
			o_valid  <= i_valid;
			o_result <= result_d;
			// tag is copied from the sideband unchanged
			o_tag    <= i_side.tag;
		end
	end

	// no stall path exists, the consumer must take each result when
	// o_valid is high because the next one may follow on the next cycle

endmodule

`default_nettype wire

/* divider/div_unit.sv */
////////////////////
// top level of the integer divide unit
// preparation, restoring core and result fixup
////////////////////

`timescale 1ns/1ps
`default_nettype none

module div_unit #(
	parameter int              XLEN       = div_pkg::XLEN,
	parameter int              TAG_W      = div_pkg::TAG_W,
	parameter logic [XLEN-1:0] STAGE_LIST = div_pkg::STAGE_LIST_DEFAULT
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_valid,
	input  div_pkg::div_op_t  i_op,
	input  logic [XLEN-1:0]   i_a,
	input  logic [XLEN-1:0]   i_b,
	input  logic [TAG_W-1:0]  i_tag,
	output logic              o_valid,
	output logic [XLEN-1:0]   o_result,
	output logic [TAG_W-1:0]  o_tag
);

	import div_pkg::*;

	// latency is the number of set mask bits plus one for the fixup register
	// with the default mask a result shows up nine cycles after issue

	// preparation to core
	logic            prep_valid;
	logic [XLEN-1:0] mag_a;
	logic [XLEN-1:0] mag_b;
	div_side_t       prep_side;

	// core to fixup
	logic            core_valid;
	logic [XLEN-1:0] core_quo;
	logic [XLEN-1:0] core_rem;
	div_side_t       core_side;

	////////////////////
	// magnitudes and flags, no clock
	////////////////////

	div_operand_prep u_prep (
		.i_valid (i_valid),
		.i_op    (i_op),
		.i_a     (i_a),
		.i_b     (i_b),
		.i_tag   (i_tag),
		.o_valid (prep_valid),
		.o_mag_a (mag_a),
		.o_mag_b (mag_b),
		.o_side  (prep_side)
	);

	////////////////////
	// unsigned divide, sideband carried alongside
	////////////////////

	div_restoring_pipe #(
		.XLEN       (XLEN),
		.STAGE_LIST (STAGE_LIST),
		.side_t     (div_side_t)
	) u_core (
		.clk         (clk),
		.rst         (rst),
		.i_valid     (prep_valid),
		.i_dividend  (mag_a),
		.i_divisor   (mag_b),
		.i_side      (prep_side),
		.o_valid     (core_valid),
		.o_quotient  (core_quo),
		.o_remainder (core_rem),
		.o_side      (core_side)
	);

	// signs applied and result registered
	div_result_fixup #(
		.XLEN  (XLEN),
		.TAG_W (TAG_W)
	) u_fixup (
		.clk         (clk),
		.rst         (rst),
		.i_valid     (core_valid),
		.i_quotient  (core_quo),
		.i_remainder (core_rem),
		.i_side      (core_side),
		.o_valid     (o_valid),
		.o_result    (o_result),
		.o_tag       (o_tag)
	);

endmodule

`default_nettype wire

/* verification/div_vectors.svh */
////////////////////
// directed vectors for the divide unit
// each row gives name, operation, dividend, divisor, tag and expected result
////////////////////

`ifndef DIV_VECTORS_SVH
`define DIV_VECTORS_SVH

task automatic load_vectors();
	// plain unsigned quotient and remainder
	add_vec("divu_basic",      DIVU, 32'd100,       32'd7,         5'd1,  32'd14);
	add_vec("remu_basic",      REMU, 32'd100,       32'd7,         5'd2,  32'd2);
	add_vec("divu_by_one",     DIVU, 32'hFFFF_FFFF, 32'd1,         5'd3,  32'hFFFF_FFFF);
	add_vec("remu_by_16",      REMU, 32'hFFFF_FFFF, 32'h10,        5'd4,  32'hF);
	add_vec("divu_small",      DIVU, 32'd5,         32'd10,        5'd5,  32'd0);
	add_vec("divu_near",       DIVU, 32'h8000_0000, 32'h8000_0001, 5'd6,  32'd0);
	add_vec("remu_near",       REMU, 32'h8000_0000, 32'h8000_0001, 5'd7,  32'h8000_0000);
	add_vec("divu_top",        DIVU, 32'hFFFF_FFFF, 32'h8000_0000, 5'd8,  32'd1);
	add_vec("remu_top",        REMU, 32'hFFFF_FFFF, 32'h8000_0000, 5'd9,  32'h7FFF_FFFF);
	// all four sign combinations, quotient truncates toward zero
	add_vec("div_pos_pos",     DIV,  32'd20,        32'd6,         5'd10, 32'd3);
	add_vec("rem_pos_pos",     REM,  32'd20,        32'd6,         5'd11, 32'd2);
	add_vec("div_neg_pos",     DIV,  32'hFFFF_FFEC, 32'd6,         5'd12, 32'hFFFF_FFFD);
	add_vec("rem_neg_pos",     REM,  32'hFFFF_FFEC, 32'd6,         5'd13, 32'hFFFF_FFFE);
	add_vec("div_pos_neg",     DIV,  32'd20,        32'hFFFF_FFFA, 5'd14, 32'hFFFF_FFFD);
	add_vec("rem_pos_neg",     REM,  32'd20,        32'hFFFF_FFFA, 5'd15, 32'd2);
	add_vec("div_neg_neg",     DIV,  32'hFFFF_FFEC, 32'hFFFF_FFFA, 5'd16, 32'd3);
	add_vec("rem_neg_neg",     REM,  32'hFFFF_FFEC, 32'hFFFF_FFFA, 5'd17, 32'hFFFF_FFFE);
	add_vec("div_exact",       DIV,  32'hFFFF_FFD6, 32'd7,         5'd18, 32'hFFFF_FFFA);
	add_vec("rem_exact",       REM,  32'hFFFF_FFD6, 32'd7,         5'd19, 32'd0);
	add_vec("div_minus_one",   DIV,  32'hFFFF_FFFF, 32'd1,         5'd20, 32'hFFFF_FFFF);
	add_vec("div_min_by_two",  DIV,  32'h8000_0000, 32'd2,         5'd21, 32'hC000_0000);
	// divide by zero for every operation
	add_vec("div_zero",        DIV,  32'h1234_5678, 32'd0,         5'd22, 32'hFFFF_FFFF);
	add_vec("div_zero_neg",    DIV,  32'hFFFF_FFEC, 32'd0,         5'd23, 32'hFFFF_FFFF);
	add_vec("divu_zero",       DIVU, 32'h1234_5678, 32'd0,         5'd24, 32'hFFFF_FFFF);
	add_vec("rem_zero_neg",    REM,  32'hFFFF_FFEC, 32'd0,         5'd25, 32'hFFFF_FFEC);
	add_vec("remu_zero",       REMU, 32'h1234_5678, 32'd0,         5'd26, 32'h1234_5678);
	// most negative value over minus one
	add_vec("div_overflow",    DIV,  32'h8000_0000, 32'hFFFF_FFFF, 5'd27, 32'h8000_0000);
	add_vec("rem_overflow",    REM,  32'h8000_0000, 32'hFFFF_FFFF, 5'd28, 32'd0);
	add_vec("divu_min_by_max", DIVU, 32'h8000_0000, 32'hFFFF_FFFF, 5'd29, 32'd0);
	add_vec("remu_min_by_max", REMU, 32'h8000_0000, 32'hFFFF_FFFF, 5'd30, 32'h8000_0000);
endtask

`endif

/* verification/tb_div_unit.sv */
////////////////////
// testbench for the integer divide unit
// directed table, random stream, reference model and timeout
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_div_unit;

	import div_pkg::*;

	localparam int          CLK_HALF     = 20;
	localparam int          RESET_CYCLES = 8;
	localparam int          NUM_RANDOM   = 200;
	localparam int          MARGIN       = 50;
	localparam logic [31:0] RAND_SEED    = 32'h77b2_206a;
	// one cycle per register stage plus the output register
	localparam int          LATENCY      = $countones(STAGE_LIST_DEFAULT) + 1;

	logic             clk;
	logic             rst;
	logic             i_valid;
	div_op_t          i_op;
	logic [XLEN-1:0]  i_a;
	logic [XLEN-1:0]  i_b;
	logic [TAG_W-1:0] i_tag;
	logic             o_valid;
	logic [XLEN-1:0]  o_result;
	logic [TAG_W-1:0] o_tag;

	// directed table filled by load_vectors
	string            vec_name [$];
	div_op_t          vec_op   [$];
	logic [XLEN-1:0]  vec_a    [$];
	logic [XLEN-1:0]  vec_b    [$];
	logic [TAG_W-1:0] vec_tag  [$];
	logic [XLEN-1:0]  vec_exp  [$];

	// outstanding operations in issue order with the cycle they must show up in
	string            exp_name   [$];
	logic [XLEN-1:0]  exp_result [$];
	logic [TAG_W-1:0] exp_tag    [$];
	int               exp_cycle  [$];

	int cycle_cnt;
	int timeout_limit;
	int pass_cnt;
	int fail_cnt;
	int other_err;

	div_unit #(
		.XLEN       (XLEN),
		.TAG_W      (TAG_W),
		.STAGE_LIST (STAGE_LIST_DEFAULT)
	) DUT (
		.clk      (clk),
		.rst      (rst),
		.i_valid  (i_valid),
		.i_op     (i_op),
		.i_a      (i_a),
		.i_b      (i_b),
		.i_tag    (i_tag),
		.o_valid  (o_valid),
		.o_result (o_result),
		.o_tag    (o_tag)
	);

	always #CLK_HALF clk = ~clk;

	task automatic add_vec(input string name, input div_op_t op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b, input logic [TAG_W-1:0] tag, input logic [XLEN-1:0] exp);
		vec_name.push_back(name);
		vec_op.push_back(op);
		vec_a.push_back(a);
		vec_b.push_back(b);
		vec_tag.push_back(tag);
		vec_exp.push_back(exp);
	endtask

	`include "div_vectors.svh"

	////////////////////
	// reference model
	////////////////////

	// signed division truncates toward zero and the remainder follows the dividend
	function automatic logic [XLEN-1:0] ref_divide(input div_op_t op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		logic signed [XLEN-1:0] sa;
		logic signed [XLEN-1:0] sb;
		logic [XLEN-1:0]        min_neg;
		logic                   ovf;
		sa      = a;
		sb      = b;
		min_neg = {1'b1, {(XLEN-1){1'b0}}};
		ovf     = (a == min_neg) && (b == '1);
		if (op == DIVU) begin
			if (b == '0) ref_divide = '1;
			else ref_divide = a / b;
		end else if (op == REMU) begin
			if (b == '0) ref_divide = a;
			else ref_divide = a % b;
		end else if (op == DIV) begin
			if (b == '0) ref_divide = '1;
			else if (ovf) ref_divide = min_neg;
			else ref_divide = sa / sb;
		end else begin
			if (b == '0) ref_divide = a;
			else if (ovf) ref_divide = '0;
			else ref_divide = sa % sb;
		end
	endfunction

	////////////////////
	// compare tasks
	////////////////////

	task automatic check_result(input string name, input logic [XLEN-1:0] expected,
			input logic [XLEN-1:0] actual, output bit ok);
		ok = (actual === expected);
		if (!ok) begin
			$display("[ERROR] %s result expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_tag(input string name, input logic [TAG_W-1:0] expected,
			input logic [TAG_W-1:0] actual, output bit ok);
		ok = (actual === expected);
		if (!ok) begin
			$display("[ERROR] %s tag expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_cycle(input string name, input int expected, input int actual,
			output bit ok);
		ok = (actual == expected);
		if (!ok) begin
			$display("[ERROR] %s arrival cycle expected %0d actual %0d",
				name, expected, actual);
		end
	endtask

	// called on a falling edge so the DUT samples at the next rising edge
	// and the result is visible at the falling edge LATENCY cycles later
	task automatic issue_op(input string name, input div_op_t op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b, input logic [TAG_W-1:0] tag, input logic [XLEN-1:0] exp);
		i_valid = 1'b1;
		i_op    = op;
		i_a     = a;
		i_b     = b;
		i_tag   = tag;
		exp_name.push_back(name);
		exp_result.push_back(exp);
		exp_tag.push_back(tag);
		exp_cycle.push_back(cycle_cnt + LATENCY);
		@(negedge clk);
	endtask

	// counts rising edges and ends the run at the cycle limit
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= timeout_limit) begin
			$display("timeout after %0d cycles, the pipeline did not deliver every result",
				cycle_cnt);
			$display("Something failed");
			$finish;
		end
	end

	////////////////////
	// output monitor
	////////////////////

	always @(negedge clk) begin : monitor
		string            name;
		logic [XLEN-1:0]  want_res;
		logic [TAG_W-1:0] want_tag;
		int               want_cycle;
		bit               res_ok;
		bit               tag_ok;
		bit               cyc_ok;
		if (rst) begin
			if (o_valid !== 1'b0) begin
				$display("o_valid was not low while reset was asserted");
				other_err++;
			end
		end else if (o_valid === 1'b1) begin
			if (exp_name.size() == 0) begin
				$display("o_valid rose at cycle %0d with no operation outstanding", cycle_cnt);
				other_err++;
			end else begin
				name       = exp_name.pop_front();
				want_res   = exp_result.pop_front();
				want_tag   = exp_tag.pop_front();
				want_cycle = exp_cycle.pop_front();
				check_result(name, want_res, o_result, res_ok);
				check_tag(name, want_tag, o_tag, tag_ok);
				check_cycle(name, want_cycle, cycle_cnt, cyc_ok);
				if (res_ok && tag_ok && cyc_ok) begin
					pass_cnt++;
					$display("pass %s", name);
				end else begin
					fail_cnt++;
					$display("fail %s", name);
				end
			end
		end else if (exp_cycle.size() != 0 && exp_cycle[0] <= cycle_cnt) begin
			// the oldest operation is due and o_valid is still low
			$display("no result arrived for %s by cycle %0d", exp_name[0], exp_cycle[0]);
			fail_cnt++;
			void'(exp_name.pop_front());
			void'(exp_result.pop_front());
			void'(exp_tag.pop_front());
			void'(exp_cycle.pop_front());
		end
	end

	////////////////////
	// stimulus
	////////////////////

	initial begin : stimulus
		int unsigned      seed_val;
		int unsigned      pick;
		logic [31:0]      rand_word;
		logic [XLEN-1:0]  ra;
		logic [XLEN-1:0]  rb;
		div_op_t          rop;
		logic [TAG_W-1:0] rtag;
		clk           = 1'b0;
		rst           = 1'b1;
		i_valid       = 1'b0;
		i_op          = DIVU;
		i_a           = '0;
		i_b           = '0;
		i_tag         = '0;
		cycle_cnt     = 0;
		pass_cnt      = 0;
		fail_cnt      = 0;
		other_err     = 0;
		timeout_limit = 1000000;
		seed_val      = $urandom(RAND_SEED);
		load_vectors();
		timeout_limit = vec_name.size() + NUM_RANDOM + LATENCY + RESET_CYCLES + MARGIN;

		// reset spans eight rising edges and is released on a falling edge
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// directed rows go in back to back and double as the streaming test
		for (int i = 0; i < vec_name.size(); i++) begin
			issue_op(vec_name[i], vec_op[i], vec_a[i], vec_b[i], vec_tag[i], vec_exp[i]);
		end

		// random stream biased toward zero divisors, small divisors and overflow
		for (int i = 0; i < NUM_RANDOM; i++) begin
			rand_word = $urandom;
			rop       = div_op_t'(rand_word[1:0]);
			rtag      = rand_word[TAG_W+1:2];
			ra        = $urandom;
			pick      = $urandom_range(7, 0);
			case (pick)
				0: rb = '0;
				1: rb = $urandom_range(255, 1);
				2: begin
					ra = {1'b1, {(XLEN-1){1'b0}}};
					rb = '1;
				end
				default: rb = $urandom;
			endcase
			issue_op($sformatf("rand_%0d", i), rop, ra, rb, rtag, ref_divide(rop, ra, rb));
		end
		i_valid = 1'b0;

		// drain and wait a couple of idle cycles to catch a stray o_valid
		while (exp_name.size() != 0) @(negedge clk);
		repeat (2) @(negedge clk);

		$display("summary %0d passed, %0d failed, %0d other errors",
			pass_cnt, fail_cnt, other_err);
		if (fail_cnt == 0 && other_err == 0 && pass_cnt == vec_name.size() + NUM_RANDOM) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
